// File: compile.f
verilog/switch_tx_pkg.sv
verilog/wb_if.sv
verilog/frame_buffer.sv
verilog/wb_arbiter.sv
verilog/frame_loader.sv
verilog/voq_fifo.sv
verilog/tx_mac_control.sv
verilog/switch_tx_top.sv
tb/switch_tx_asserts.sv
tb/switch_tx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module switch_tx_tb -f compile.f -o sim_switch_tx
./obj_dir/sim_switch_tx 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: tb/switch_tx_asserts.sv
// mac bus and gmii checks
`timescale 1ns/100ps

module switch_tx_asserts import switch_tx_pkg::*; (
    input logic      gmii_tx_clk_o,
    input logic      switch_rst_n,
    input logic      tx_er_i,
    input logic      cyc_i,
    input logic      stb_i,
    input logic      ack_i,
    input buf_addr_t adr_i
);

    // er only comes from a prefetch underrun
    no_tx_er: assert property (@(posedge gmii_tx_clk_o) disable iff (!switch_rst_n)
        !tx_er_i) else $error("gmii_tx_er_o high");

    // arbiter hands ack only to a mac that is requesting
    ack_in_req: assert property (@(posedge gmii_tx_clk_o) disable iff (!switch_rst_n)
        ack_i |-> (cyc_i && stb_i)) else $error("mac ack outside a request");

    // a read waits on the bus unchanged until the arbiter lets it through
    req_held: assert property (@(posedge gmii_tx_clk_o) disable iff (!switch_rst_n)
        (stb_i && !ack_i) |=> (stb_i && $stable(adr_i)))
        else $error("mac request dropped or moved before ack");

endmodule

bind tx_mac_control switch_tx_asserts u_asserts (
    .gmii_tx_clk_o (gmii_tx_clk_o),
    .switch_rst_n  (switch_rst_n),
    .tx_er_i       (gmii_tx_er_o),
    .cyc_i         (bus.cyc),
    .stb_i         (bus.stb),
    .ack_i         (bus.ack),
    .adr_i         (bus.adr)
);

// File: tb/switch_tx_tb.sv
// switch egress testbench
`timescale 1ns/100ps

module switch_tx_tb import switch_tx_pkg::*; ();

    localparam int NUM_FRAMES     = 40;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_FRAME_BYTES * 4 + 40);

    logic                  gmii_tx_clk_o;
    logic                  switch_rst_n;
    logic                  load_valid_i;
    logic [DATA_WIDTH-1:0] load_data_i;
    logic                  load_last_i;
    logic                  load_ready_o;
    logic [DATA_WIDTH-1:0] gmii_tx_data_o;
    logic                  gmii_tx_en_o;
    logic                  gmii_tx_er_o;

    logic [DATA_WIDTH-1:0] exp_bytes [$];  // every accepted byte, in load order
    int                    exp_lens [$];   // one entry per loaded frame
    int                    rx_frames;
    int                    rx_pos;         // enabled cycles so far in this frame
    int                    idle_cnt;       // cycles with tx_en low
    logic                  stall_seen;     // valid held while ready was low

    switch_tx_top dut_i (
        .gmii_tx_clk_o  (gmii_tx_clk_o),
        .switch_rst_n   (switch_rst_n),
        .load_valid_i   (load_valid_i),
        .load_data_i    (load_data_i),
        .load_last_i    (load_last_i),
        .load_ready_o   (load_ready_o),
        .gmii_tx_data_o (gmii_tx_data_o),
        .gmii_tx_en_o   (gmii_tx_en_o),
        .gmii_tx_er_o   (gmii_tx_er_o)
    );

    always #10 gmii_tx_clk_o = ~gmii_tx_clk_o;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_byte(input string name, input logic [DATA_WIDTH-1:0] got,
                                input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_len(input string name, input buf_hdr_t got, input buf_hdr_t exp);
        if (got.len !== exp.len) begin
            report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got.len,
                                     exp.len));
        end
    endtask

    // one frame of random bytes, with random gaps in valid
    task automatic send_frame(input int len);
        int   sent;
        logic hold;
        sent = 0;
        while (sent < len) begin
            @(posedge gmii_tx_clk_o);
            hold = 1'b0;
            if (load_valid_i && load_ready_o) begin
                exp_bytes.push_back(load_data_i);
                sent++;
            end else if (load_valid_i) begin
                stall_seen = 1'b1;
                hold       = 1'b1;  // byte stays on the bus
            end
            if (!hold) begin
                if (sent < len && $urandom_range(3, 0) != 0) begin
                    load_valid_i <= 1'b1;
                    load_data_i  <= DATA_WIDTH'($urandom);
                    load_last_i  <= (sent == len - 1);
                end else begin
                    load_valid_i <= 1'b0;
                    load_last_i  <= 1'b0;
                end
            end
        end
        exp_lens.push_back(len);
    endtask

    // frame done on the line, check its length against the model
    task automatic close_frame();
        buf_hdr_t got;
        buf_hdr_t exp;
        if (exp_lens.size() == 0) begin
            report_failure("GMII sent a frame that was never loaded");
        end
        got.len = BUF_WORD_W'(rx_pos - PREAMBLE_LEN - 1);
        exp.len = BUF_WORD_W'(exp_lens.pop_front());
        compare_len("frame length", got, exp);
        rx_frames++;
        rx_pos = 0;
    endtask

    // gmii monitor, sampled mid-cycle
    always @(negedge gmii_tx_clk_o) begin
        if (switch_rst_n) begin
            if (gmii_tx_er_o) begin
                report_failure("gmii_tx_er_o was raised, the MAC prefetch FIFO ran dry");
            end
            if (gmii_tx_en_o) begin
                if (rx_pos == 0 && rx_frames > 0 && idle_cnt < IFG_BYTES) begin
                    report_failure($sformatf("inter-frame gap of %0d cycles is too short",
                                             idle_cnt));
                end
                if (rx_pos < PREAMBLE_LEN) begin
                    compare_byte("gmii_tx_data_o", gmii_tx_data_o, PREAMBLE_BYTE);
                end else if (rx_pos == PREAMBLE_LEN) begin
                    compare_byte("gmii_tx_data_o", gmii_tx_data_o, SFD_BYTE);
                end else if (exp_bytes.size() == 0) begin
                    report_failure("GMII sent a data byte that was never loaded");
                end else begin
                    compare_byte("gmii_tx_data_o", gmii_tx_data_o, exp_bytes.pop_front());
                end
                rx_pos++;
                idle_cnt = 0;
            end else begin
                if (rx_pos != 0) close_frame();
                idle_cnt++;
            end
        end
    end

    initial begin
        int len;
        void'($urandom(81));
        gmii_tx_clk_o = 1'b0;
        switch_rst_n  = 1'b0;
        load_valid_i  = 1'b0;
        load_data_i   = '0;
        load_last_i   = 1'b0;
        rx_frames     = 0;
        rx_pos        = 0;
        idle_cnt      = 0;
        stall_seen    = 1'b0;
        repeat (3) @(posedge gmii_tx_clk_o);
        switch_rst_n <= 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            len = int'($urandom_range(MAX_FRAME_BYTES, MIN_FRAME_BYTES));
            send_frame(len);
        end

        while (rx_frames < NUM_FRAMES) @(posedge gmii_tx_clk_o);
        repeat (IFG_BYTES * 2) @(posedge gmii_tx_clk_o);  // nothing extra may follow

        if (rx_frames == NUM_FRAMES && exp_bytes.size() == 0 && exp_lens.size() == 0 &&
            stall_seen) begin
            $display("Test OK");
            $finish;
        end else begin
            report_failure($sformatf("end of run with %0d frames, %0d bytes left, stall %0b",
                                     rx_frames, exp_bytes.size(), stall_seen));
        end
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge gmii_tx_clk_o);
        report_failure($sformatf("run timed out after %0d cycles with %0d frames received",
                                 TIMEOUT_CYCLES, rx_frames));
    end

endmodule

// File: verilog/frame_buffer.sv
// shared frame memory
`timescale 1ns/100ps

module frame_buffer import switch_tx_pkg::*; (
    input  logic gmii_tx_clk_o,
    input  logic switch_rst_n,
    wb_if.slave  bus
);

    buf_word_u mem [BUF_DEPTH];
    logic      ready_q;  // bus held off for the first cycle out of reset

    always_ff @(posedge gmii_tx_clk_o or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    // write port
    always_ff @(posedge gmii_tx_clk_o) begin
        if (bus.cyc && bus.stb && bus.we && ready_q) begin
            mem[bus.adr] <= bus.dat_w;
        end
    end

    // async read, so ack can come back in the request cycle
    assign bus.dat_r = mem[bus.adr];
    assign bus.ack   = bus.cyc && bus.stb && ready_q;

endmodule

// File: verilog/frame_loader.sv
// fabric side frame loader
`timescale 1ns/100ps

module frame_loader import switch_tx_pkg::*; (
    input  logic                  gmii_tx_clk_o,
    input  logic                  switch_rst_n,
    input  logic                  load_valid_i,
    input  logic [DATA_WIDTH-1:0] load_data_i,
    input  logic                  load_last_i,   // last byte of the frame
    output logic                  load_ready_o,
    wb_if.master                  bus,
    output logic                  voq_push_o,
    output buf_addr_t             voq_ptr_o,
    input  logic                  voq_ready_i,
    input  logic                  rel_valid_i,   // mac finished a frame
    input  logic [BUF_WORD_W-1:0] rel_words_i
);

    typedef enum logic [1:0] {IDLE, WR_DATA, WR_HDR, PUSH} state_t;

    state_t                state_q;
    buf_addr_t             wr_adr_q;     // next free word
    buf_addr_t             start_adr_q;  // header slot of the current frame
    logic [DATA_WIDTH-1:0] data_q;
    logic                  last_q;
    logic                  run_q;
    logic [BUF_WORD_W-1:0] byte_cnt_q;
    logic [BUF_AW:0]       used_q;       // words held in the buffer
    logic [BUF_AW:0]       rel_sub;
    logic                  room_ok;
    logic                  accept;
    logic                  wr_req;
    logic                  wr_done;

    // a whole frame plus header must fit before a new frame starts
    assign room_ok = (BUF_DEPTH - int'(used_q)) >= (MAX_FRAME_BYTES + 1);

    assign load_ready_o = run_q && (state_q == IDLE) &&
                          (byte_cnt_q != '0 || (room_ok && voq_ready_i));
    assign accept       = load_valid_i && load_ready_o;

    assign wr_req    = (state_q == WR_DATA) || (state_q == WR_HDR);
    assign wr_done   = wr_req && bus.ack;
    assign bus.cyc   = wr_req;
    assign bus.stb   = wr_req;
    assign bus.we    = 1'b1;
    assign bus.adr   = (state_q == WR_HDR) ? start_adr_q : wr_adr_q;

    always_comb begin
        bus.dat_w = '0;
        if (state_q == WR_HDR) begin
            bus.dat_w.hdr.len = byte_cnt_q;
        end else begin
            bus.dat_w.dat.data = data_q;
        end
    end

    assign voq_push_o = (state_q == PUSH);
    assign voq_ptr_o  = start_adr_q;
    assign rel_sub    = rel_valid_i ? rel_words_i[BUF_AW:0] : '0;

    always_ff @(posedge gmii_tx_clk_o or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state_q    <= IDLE;
            wr_adr_q   <= '0;
            byte_cnt_q <= '0;
            used_q     <= '0;
            run_q      <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            used_q <= used_q + {{BUF_AW{1'b0}}, wr_done} - rel_sub;
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == '0) begin
                            wr_adr_q <= wr_adr_q + 1'b1;  // skip the header slot
                        end
                        state_q <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wr_done) begin
                        wr_adr_q <= wr_adr_q + 1'b1;
                        state_q  <= last_q ? WR_HDR : IDLE;
                    end
                end
                WR_HDR: begin
                    if (wr_done) state_q <= PUSH;
                end
                PUSH: begin
                    if (voq_ready_i) begin
                        byte_cnt_q <= '0;
                        state_q    <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // byte and frame start capture
    always_ff @(posedge gmii_tx_clk_o) begin
        if (accept) begin
            data_q <= load_data_i;
            last_q <= load_last_i;
            if (byte_cnt_q == '0) start_adr_q <= wr_adr_q;
        end
    end

endmodule

// File: verilog/switch_tx_pkg.sv
// switch egress shared definitions
package switch_tx_pkg;

    localparam int DATA_WIDTH      = 8;   // gmii byte
    localparam int BUF_DEPTH       = 256;
    localparam int BUF_AW          = 8;
    localparam int VOQ_DEPTH       = 4;
    localparam int VOQ_AW          = 2;
    localparam int MAX_FRAME_BYTES = 64;
    localparam int MIN_FRAME_BYTES = 1;
    localparam int PREAMBLE_LEN    = 7;
    localparam int IFG_BYTES       = 12;
    localparam int PREFETCH_DEPTH  = 4;   // mac read-ahead
    localparam int BUF_WORD_W      = 12;

    localparam logic [DATA_WIDTH-1:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [DATA_WIDTH-1:0] SFD_BYTE      = 8'hD5;

    typedef logic [BUF_AW-1:0] buf_addr_t;

    // first word of a frame
    typedef struct packed {
        logic [BUF_WORD_W-1:0] len;  // frame length in bytes
    } buf_hdr_t;

    // every later word
    typedef struct packed {
        logic [3:0]            rsvd;
        logic [DATA_WIDTH-1:0] data;
    } buf_dat_t;

    typedef union packed {
        buf_hdr_t hdr;
        buf_dat_t dat;
    } buf_word_u;

endpackage

// File: verilog/switch_tx_top.sv
// switch port egress top level
`timescale 1ns/100ps

module switch_tx_top import switch_tx_pkg::*; (
    input  logic                  gmii_tx_clk_o,  // generated outside, gmii name kept
    input  logic                  switch_rst_n,
    input  logic                  load_valid_i,
    input  logic [DATA_WIDTH-1:0] load_data_i,
    input  logic                  load_last_i,
    output logic                  load_ready_o,
    output logic [DATA_WIDTH-1:0] gmii_tx_data_o,
    output logic                  gmii_tx_en_o,
    output logic                  gmii_tx_er_o
);

    wb_if wb_ldr ();
    wb_if wb_mac ();
    wb_if wb_mem ();

    logic                  voq_push;
    logic                  voq_push_ready;
    buf_addr_t             voq_push_ptr;
    logic                  voq_pop_valid;
    logic                  voq_pop_ready;
    buf_addr_t             voq_pop_ptr;
    logic                  rel_valid;
    logic [BUF_WORD_W-1:0] rel_words;

    frame_loader u_loader (
        .gmii_tx_clk_o (gmii_tx_clk_o),
        .switch_rst_n  (switch_rst_n),
        .load_valid_i  (load_valid_i),
        .load_data_i   (load_data_i),
        .load_last_i   (load_last_i),
        .load_ready_o  (load_ready_o),
        .bus           (wb_ldr.master),
        .voq_push_o    (voq_push),
        .voq_ptr_o     (voq_push_ptr),
        .voq_ready_i   (voq_push_ready),
        .rel_valid_i   (rel_valid),
        .rel_words_i   (rel_words)
    );

    voq_fifo u_voq (
        .gmii_tx_clk_o (gmii_tx_clk_o),
        .switch_rst_n  (switch_rst_n),
        .push_valid_i  (voq_push),
        .push_ptr_i    (voq_push_ptr),
        .push_ready_o  (voq_push_ready),
        .pop_valid_o   (voq_pop_valid),
        .pop_ptr_o     (voq_pop_ptr),
        .pop_ready_i   (voq_pop_ready)
    );

    tx_mac_control u_mac (
        .gmii_tx_clk_o  (gmii_tx_clk_o),
        .switch_rst_n   (switch_rst_n),
        .voq_valid_i    (voq_pop_valid),
        .voq_ptr_i      (voq_pop_ptr),
        .voq_ready_o    (voq_pop_ready),
        .bus            (wb_mac.master),
        .gmii_tx_data_o (gmii_tx_data_o),
        .gmii_tx_en_o   (gmii_tx_en_o),
        .gmii_tx_er_o   (gmii_tx_er_o),
        .rel_valid_o    (rel_valid),
        .rel_words_o    (rel_words)
    );

    // mac and loader share the one buffer port
    wb_arbiter u_arb (
        .gmii_tx_clk_o (gmii_tx_clk_o),
        .switch_rst_n  (switch_rst_n),
        .mac_bus       (wb_mac.slave),
        .ldr_bus       (wb_ldr.slave),
        .mem_bus       (wb_mem.master)
    );

    frame_buffer u_buf (
        .gmii_tx_clk_o (gmii_tx_clk_o),
        .switch_rst_n  (switch_rst_n),
        .bus           (wb_mem.slave)
    );

endmodule

// File: verilog/tx_mac_control.sv
// gmii transmit mac with wishbone prefetch
`timescale 1ns/100ps

module tx_mac_control import switch_tx_pkg::*; (
    input  logic                  gmii_tx_clk_o,
    input  logic                  switch_rst_n,
    input  logic                  voq_valid_i,  // start address waiting
    input  buf_addr_t             voq_ptr_i,
    output logic                  voq_ready_o,
    wb_if.master                  bus,
    output logic [DATA_WIDTH-1:0] gmii_tx_data_o,
    output logic                  gmii_tx_en_o,
    output logic                  gmii_tx_er_o,
    output logic                  rel_valid_o,  // one cycle at frame end
    output logic [BUF_WORD_W-1:0] rel_words_o
);

    typedef enum logic [1:0] {IDLE, PREAMBLE, DATA, IFG} state_t;

    state_t                state_q;
    logic                  hdr_done_q;    // length known
    logic [2:0]            pre_cnt_q;     // 7 preamble + sfd
    logic [3:0]            ifg_cnt_q;
    logic [BUF_WORD_W-1:0] fetch_left_q;  // bytes still to read
    logic [BUF_WORD_W-1:0] tx_left_q;     // bytes still to send
    logic [BUF_WORD_W-1:0] len_q;
    buf_addr_t             fetch_adr_q;

    // prefetch fifo
    logic [DATA_WIDTH-1:0]             pf_mem [PREFETCH_DEPTH];
    logic [$clog2(PREFETCH_DEPTH)-1:0] pf_wr_q;
    logic [$clog2(PREFETCH_DEPTH)-1:0] pf_rd_q;
    logic [$clog2(PREFETCH_DEPTH):0]   pf_cnt_q;
    logic                              pf_full;
    logic                              pf_push;
    logic                              pf_pop;

    logic pop;
    logic hdr_req;
    logic dat_req;
    logic bus_done;
    logic tx_go;

    assign voq_ready_o = (state_q == IDLE);
    assign pop         = voq_valid_i && voq_ready_o;

    // fetch engine, header first then data until fifo full or frame done
    assign pf_full  = int'(pf_cnt_q) == PREFETCH_DEPTH;
    assign hdr_req  = (state_q == PREAMBLE) && !hdr_done_q;
    assign dat_req  = hdr_done_q && (fetch_left_q != '0) && !pf_full &&
                      (state_q == PREAMBLE || state_q == DATA);
    assign bus.cyc   = hdr_req || dat_req;
    assign bus.stb   = hdr_req || dat_req;
    assign bus.we    = 1'b0;
    assign bus.adr   = fetch_adr_q;
    assign bus.dat_w = '0;
    assign bus_done  = (hdr_req || dat_req) && bus.ack;

    assign pf_push = bus_done && hdr_done_q;
    assign pf_pop  = (state_q == DATA) && (pf_cnt_q != '0);

    // preamble only starts once the fifo holds enough to run without gaps
    assign tx_go = (state_q == PREAMBLE) &&
                   (pre_cnt_q != '0 || (hdr_done_q && (pf_full || fetch_left_q == '0)));

    assign rel_words_o = len_q + 1'b1;  // header word included

    always_ff @(posedge gmii_tx_clk_o) begin
        if (pf_push) pf_mem[pf_wr_q] <= bus.dat_r.dat.data;
        if (bus_done) fetch_adr_q <= fetch_adr_q + 1'b1;
        if (bus_done && !hdr_done_q) len_q <= bus.dat_r.hdr.len;
        if (pop) fetch_adr_q <= voq_ptr_i;
    end

    always_ff @(posedge gmii_tx_clk_o or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state_q        <= IDLE;
            hdr_done_q     <= 1'b0;
            pre_cnt_q      <= '0;
            ifg_cnt_q      <= '0;
            fetch_left_q   <= '0;
            tx_left_q      <= '0;
            pf_wr_q        <= '0;
            pf_rd_q        <= '0;
            pf_cnt_q       <= '0;
            gmii_tx_data_o <= '0;
            gmii_tx_en_o   <= 1'b0;
            gmii_tx_er_o   <= 1'b0;
            rel_valid_o    <= 1'b0;
        end else begin
            gmii_tx_data_o <= '0;
            gmii_tx_en_o   <= 1'b0;
            gmii_tx_er_o   <= 1'b0;
            rel_valid_o    <= 1'b0;

            if (pf_push) pf_wr_q <= pf_wr_q + 1'b1;
            if (pf_pop) pf_rd_q <= pf_rd_q + 1'b1;
            case ({pf_push, pf_pop})
                2'b10:   pf_cnt_q <= pf_cnt_q + 1'b1;
                2'b01:   pf_cnt_q <= pf_cnt_q - 1'b1;
                default: pf_cnt_q <= pf_cnt_q;
            endcase
            if (pf_push) fetch_left_q <= fetch_left_q - 1'b1;

            case (state_q)
                IDLE: begin
                    if (pop) begin
                        hdr_done_q <= 1'b0;
                        pre_cnt_q  <= '0;
                        state_q    <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    if (bus_done && !hdr_done_q) begin
                        hdr_done_q   <= 1'b1;
                        fetch_left_q <= bus.dat_r.hdr.len;
                    end
                    if (tx_go) begin
                        gmii_tx_en_o   <= 1'b1;
                        gmii_tx_data_o <= (pre_cnt_q == 3'(PREAMBLE_LEN)) ? SFD_BYTE
                                                                         : PREAMBLE_BYTE;
                        pre_cnt_q      <= pre_cnt_q + 1'b1;
                        if (pre_cnt_q == 3'(PREAMBLE_LEN)) begin
                            tx_left_q <= len_q;
                            state_q   <= DATA;
                        end
                    end
                end
                DATA: begin
                    gmii_tx_en_o   <= 1'b1;
                    gmii_tx_er_o   <= !pf_pop;  // fifo ran dry
                    gmii_tx_data_o <= pf_mem[pf_rd_q];
                    tx_left_q      <= tx_left_q - 1'b1;
                    if (tx_left_q == BUF_WORD_W'(1)) begin
                        rel_valid_o <= 1'b1;
                        ifg_cnt_q   <= '0;
                        state_q     <= IFG;
                    end
                end
                IFG: begin
                    ifg_cnt_q <= ifg_cnt_q + 1'b1;
                    if (ifg_cnt_q == 4'(IFG_BYTES - 1)) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// File: verilog/voq_fifo.sv
// virtual output queue of frame start addresses
`timescale 1ns/100ps

module voq_fifo import switch_tx_pkg::*; (
    input  logic      gmii_tx_clk_o,
    input  logic      switch_rst_n,
    input  logic      push_valid_i,
    input  buf_addr_t push_ptr_i,
    output logic      push_ready_o,
    output logic      pop_valid_o,
    output buf_addr_t pop_ptr_o,
    input  logic      pop_ready_i
);

    buf_addr_t         slots [VOQ_DEPTH];
    logic [VOQ_AW-1:0] wr_q;
    logic [VOQ_AW-1:0] rd_q;
    logic [VOQ_AW:0]   cnt_q;
    logic              push;
    logic              pop;

    assign push_ready_o = int'(cnt_q) != VOQ_DEPTH;
    assign pop_valid_o  = cnt_q != '0;
    assign pop_ptr_o    = slots[rd_q];  // head of queue

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge gmii_tx_clk_o) begin
        if (push) slots[wr_q] <= push_ptr_i;
    end

    always_ff @(posedge gmii_tx_clk_o or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            wr_q  <= '0;
            rd_q  <= '0;
            cnt_q <= '0;
        end else begin
            if (push) wr_q <= wr_q + 1'b1;
            if (pop) rd_q <= rd_q + 1'b1;
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;  // none or both
            endcase
        end
    end

endmodule

// File: verilog/wb_arbiter.sv
// two-master wishbone arbiter, mac first
`timescale 1ns/100ps

module wb_arbiter (
    input  logic  gmii_tx_clk_o,
    input  logic  switch_rst_n,
    wb_if.slave   mac_bus,
    wb_if.slave   ldr_bus,
    wb_if.master  mem_bus
);

    logic gnt_mac_q;  // current owner, 1 = mac
    logic gnt_mac;    // owner for this cycle

    // owner keeps the bus until it drops cyc
    always_comb begin
        gnt_mac = gnt_mac_q;
        if (gnt_mac_q ? !mac_bus.cyc : !ldr_bus.cyc) begin
            if (mac_bus.cyc) begin
                gnt_mac = 1'b1;
            end else if (ldr_bus.cyc) begin
                gnt_mac = 1'b0;
            end
        end
    end

    always_ff @(posedge gmii_tx_clk_o or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            gnt_mac_q <= 1'b1;
        end else begin
            gnt_mac_q <= gnt_mac;
        end
    end

    // request mux
    assign mem_bus.cyc   = gnt_mac ? mac_bus.cyc   : ldr_bus.cyc;
    assign mem_bus.stb   = gnt_mac ? mac_bus.stb   : ldr_bus.stb;
    assign mem_bus.we    = gnt_mac ? mac_bus.we    : ldr_bus.we;
    assign mem_bus.adr   = gnt_mac ? mac_bus.adr   : ldr_bus.adr;
    assign mem_bus.dat_w = gnt_mac ? mac_bus.dat_w : ldr_bus.dat_w;

    // read data to both, ack only to the owner
    assign mac_bus.dat_r = mem_bus.dat_r;
    assign ldr_bus.dat_r = mem_bus.dat_r;
    assign mac_bus.ack   = gnt_mac && mem_bus.ack;
    assign ldr_bus.ack   = !gnt_mac && mem_bus.ack;

endmodule

// File: verilog/wb_if.sv
// wishbone classic bus
`timescale 1ns/100ps

interface wb_if import switch_tx_pkg::*; ();

    logic      cyc;
    logic      stb;
    logic      we;
    buf_addr_t adr;
    buf_word_u dat_w;
    buf_word_u dat_r;
    logic      ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface
